// File: build.f
+incdir+hw
hw/rv_decode_pkg.sv
hw/rv_op_decoder.sv
hw/rv_operand_extract.sv
hw/rv_decode_queue.sv
hw/rv_decode_top.sv
test/rv_decode_properties.sv
test/rv_decode_tb.sv

// File: hw/rv_decode_cfg.svh
`ifndef RV_DECODE_CFG_SVH
`define RV_DECODE_CFG_SVH

// data and address width of the core
`define RV_XLEN 32

// records the decode queue can hold
`define RV_QUEUE_DEPTH 2

// exception cause reported for an invalid instruction
`define RV_CAUSE_ILLEGAL 4'd2

`endif

// File: hw/rv_decode_pkg.sv
`include "rv_decode_cfg.svh"

package rv_decode_pkg;

    // major opcodes in bits 6 to 2 of the word
    typedef enum logic [4:0] {
        opc_load   = 5'b00000,
        opc_op_imm = 5'b00100,
        opc_auipc  = 5'b00101,
        opc_store  = 5'b01000,
        opc_op     = 5'b01100,
        opc_lui    = 5'b01101,
        opc_branch = 5'b11000,
        opc_jalr   = 5'b11001,
        opc_jal    = 5'b11011,
        opc_system = 5'b11100,
        opc_custom = 5'b11111
    } opcode_e;

    typedef enum logic [3:0] {
        cls_alu_reg,
        cls_alu_imm,
        cls_branch,
        cls_jal,
        cls_jalr,
        cls_lui,
        cls_auipc,
        cls_load,
        cls_store,
        cls_csr,
        cls_system,
        cls_custom,
        cls_illegal
    } op_class_e;

    typedef enum logic [5:0] {
        op_none,
        op_add, op_sub, op_sll, op_slt, op_sltu,
        op_xor, op_srl, op_sra, op_or, op_and,
        op_addi, op_slti, op_sltiu, op_xori, op_ori,
        op_andi, op_slli, op_srli, op_srai,
        op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
        op_jal, op_jalr, op_lui, op_auipc,
        op_lb, op_lh, op_lw, op_lbu, op_lhu,
        op_sb, op_sh, op_sw,
        op_csrrw, op_csrrs, op_csrrc, op_csrrwi, op_csrrsi, op_csrrci,
        op_ecall, op_ebreak, op_mret, op_sret, op_wfi,
        op_custom
    } op_e;

    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;
        logic [31:0]         word;
    } fetch_t;

    typedef struct packed {
        op_class_e op_class;
        op_e       op;
        logic      illegal;
    } op_dec_t;

    typedef struct packed {
        logic [4:0]          rd;
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        logic [`RV_XLEN-1:0] imm;
        logic [`RV_XLEN-1:0] target;
    } operand_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;
        op_class_e           op_class;
        op_e                 op;
        logic [4:0]          rd;
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        logic [`RV_XLEN-1:0] imm;
        logic [`RV_XLEN-1:0] target;
        logic [3:0]          cause; // 0 when legal
    } decoded_t;

endpackage

// File: hw/rv_decode_queue.sv
`include "rv_decode_cfg.svh"

module rv_decode_queue (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  logic [`RV_XLEN-1:0]     pc,
    input  rv_decode_pkg::op_dec_t  dec,
    input  rv_decode_pkg::operand_t opnd,
    output logic                    out_valid,
    input  logic                    out_ready,
    output rv_decode_pkg::decoded_t out_data
);
    import rv_decode_pkg::*;

    localparam int ptr_w = (`RV_QUEUE_DEPTH > 1) ? $clog2(`RV_QUEUE_DEPTH) : 1;
    localparam int cnt_w = $clog2(`RV_QUEUE_DEPTH + 1);

    decoded_t         rec;
    decoded_t         mem [`RV_QUEUE_DEPTH];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             push;
    logic             pop;

    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
        next_ptr = (p == ptr_w'(`RV_QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    always_comb begin
        rec.pc       = pc;
        rec.op_class = dec.op_class;
        rec.op       = dec.op;
        rec.rd       = opnd.rd;
        rec.rs1      = opnd.rs1;
        rec.rs2      = opnd.rs2;
        rec.imm      = opnd.imm;
        rec.target   = opnd.target;
        rec.cause    = '0;
        if (dec.illegal) begin
            rec.op_class = cls_illegal;
            rec.op       = op_none;
            rec.rd       = '0;
            rec.rs1      = '0;
            rec.rs2      = '0;
            rec.imm      = '0;
            rec.target   = '0;
            rec.cause    = `RV_CAUSE_ILLEGAL; // pc is kept
        end
    end

    assign in_ready  = (count < cnt_w'(`RV_QUEUE_DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= rec;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // idle or pass-through
            endcase
        end
    end

endmodule

// File: hw/rv_decode_top.sv
module rv_decode_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  rv_decode_pkg::fetch_t   in_data,
    output logic                    out_valid,
    input  logic                    out_ready,
    output rv_decode_pkg::decoded_t out_data
);
    import rv_decode_pkg::*;

    op_dec_t  dec;
    operand_t opnd;

    rv_op_decoder i_op_decoder (
        .inst (in_data),
        .dec  (dec)
    );

    rv_operand_extract i_operand_extract (
        .inst (in_data),
        .opnd (opnd)
    );

    rv_decode_queue i_decode_queue (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .pc        (in_data.pc),
        .dec       (dec),
        .opnd      (opnd),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

endmodule

// File: hw/rv_op_decoder.sv
module rv_op_decoder (
    input  rv_decode_pkg::fetch_t  inst,
    output rv_decode_pkg::op_dec_t dec
);
    import rv_decode_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    op_class_e  cls;
    op_e        op;
    logic       bad;

    assign opcode = opcode_e'(inst.word[6:2]);
    assign funct3 = inst.word[14:12];
    assign funct7 = inst.word[31:25];

    always_comb begin
        cls = cls_illegal;
        op  = op_none;
        bad = 1'b0;
        if (inst.word[1:0] != 2'b11) begin
            bad = 1'b1; // compressed or malformed
        end else begin
            case (opcode)
                opc_op: begin
                    cls = cls_alu_reg;
                    case (funct3)
                        3'b000:  op = inst.word[30] ? op_sub : op_add;
                        3'b001:  op = op_sll;
                        3'b010:  op = op_slt;
                        3'b011:  op = op_sltu;
                        3'b100:  op = op_xor;
                        3'b101:  op = inst.word[30] ? op_sra : op_srl;
                        3'b110:  op = op_or;
                        default: op = op_and;
                    endcase
                end
                opc_op_imm: begin
                    cls = cls_alu_imm;
                    case (funct3)
                        3'b000: op = op_addi;
                        3'b001: begin
                            op  = op_slli;
                            bad = (funct7 != 7'b0000000);
                        end
                        3'b010: op = op_slti;
                        3'b011: op = op_sltiu;
                        3'b100: op = op_xori;
                        3'b101: begin
                            if (funct7 == 7'b0000000) begin
                                op = op_srli;
                            end else if (funct7 == 7'b0100000) begin
                                op = op_srai;
                            end else begin
                                bad = 1'b1; // bad shift funct7
                            end
                        end
                        3'b110:  op = op_ori;
                        default: op = op_andi;
                    endcase
                end
                opc_branch: begin
                    cls = cls_branch;
                    case (funct3)
                        3'b000:  op = op_beq;
                        3'b001:  op = op_bne;
                        3'b100:  op = op_blt;
                        3'b101:  op = op_bge;
                        3'b110:  op = op_bltu;
                        3'b111:  op = op_bgeu;
                        default: bad = 1'b1;
                    endcase
                end
                opc_jalr: begin
                    cls = cls_jalr;
                    op  = op_jalr;
                    bad = (funct3 != 3'b000);
                end
                opc_jal: begin
                    cls = cls_jal;
                    op  = op_jal;
                end
                opc_lui: begin
                    cls = cls_lui;
                    op  = op_lui;
                end
                opc_auipc: begin
                    cls = cls_auipc;
                    op  = op_auipc;
                end
                opc_load: begin
                    cls = cls_load;
                    case (funct3)
                        3'b000:  op = op_lb;
                        3'b001:  op = op_lh;
                        3'b010:  op = op_lw;
                        3'b100:  op = op_lbu;
                        3'b101:  op = op_lhu;
                        default: bad = 1'b1;
                    endcase
                end
                opc_store: begin
                    cls = cls_store;
                    case (funct3)
                        3'b000:  op = op_sb;
                        3'b001:  op = op_sh;
                        3'b010:  op = op_sw;
                        default: bad = 1'b1;
                    endcase
                end
                opc_system: begin
                    if (funct3 == 3'b000) begin
                        cls = cls_system;
                        case (inst.word) // only exact encodings
                            32'h00000073: op = op_ecall;
                            32'h00100073: op = op_ebreak;
                            32'h30200073: op = op_mret;
                            32'h10200073: op = op_sret;
                            32'h10500073: op = op_wfi;
                            default:      bad = 1'b1;
                        endcase
                    end else begin
                        cls = cls_csr;
                        case (funct3)
                            3'b001:  op = op_csrrw;
                            3'b010:  op = op_csrrs;
                            3'b011:  op = op_csrrc;
                            3'b101:  op = op_csrrwi;
                            3'b110:  op = op_csrrsi;
                            3'b111:  op = op_csrrci;
                            default: bad = 1'b1;
                        endcase
                    end
                end
                opc_custom: begin
                    cls = cls_custom;
                    op  = op_custom;
                end
                default: bad = 1'b1;
            endcase
        end
    end

    assign dec.illegal  = bad;
    assign dec.op_class = bad ? cls_illegal : cls;
    assign dec.op       = bad ? op_none : op;

endmodule

// File: hw/rv_operand_extract.sv
`include "rv_decode_cfg.svh"

module rv_operand_extract (
    input  rv_decode_pkg::fetch_t   inst,
    output rv_decode_pkg::operand_t opnd
);
    import rv_decode_pkg::*;

    logic [31:0]         w;
    opcode_e             opcode;
    logic [`RV_XLEN-1:0] imm;

    assign w      = inst.word;
    assign opcode = opcode_e'(w[6:2]);

    always_comb begin
        case (opcode)
            opc_op_imm, opc_load, opc_jalr, opc_system: begin
                imm = {{20{w[31]}}, w[31:20]}; // I format
            end
            opc_store: begin
                imm = {{20{w[31]}}, w[31:25], w[11:7]}; // S format
            end
            opc_branch: begin
                imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            end
            opc_lui, opc_auipc: begin
                imm = {w[31:12], 12'b0};
            end
            opc_jal: begin
                imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            default: begin
                imm = '0; // R-type, custom
            end
        endcase
    end

    assign opnd.rd     = w[11:7];
    assign opnd.rs1    = w[19:15];
    assign opnd.rs2    = w[24:20];
    assign opnd.imm    = imm;
    assign opnd.target = inst.pc + imm; // branch, jump or auipc value

endmodule

// File: run.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module rv_decode_tb \
    -f build.f \
    -Mdir obj_dir -o rv_decode_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed"
    exit $status
fi

./obj_dir/rv_decode_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed"
    exit $status
fi

exit 0

// File: test/rv_decode_properties.sv
`include "rv_decode_cfg.svh"

module rv_decode_properties (
    input logic                    clk,
    input logic                    rst,
    input logic                    in_valid,
    input logic                    in_ready,
    input logic                    out_valid,
    input logic                    out_ready,
    input rv_decode_pkg::decoded_t out_data
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int cnt_w = $clog2(`RV_QUEUE_DEPTH + 1);

    logic [cnt_w-1:0] waiting; // records held in the queue
    logic             in_fire;
    logic             out_fire;

    assign in_fire  = in_valid && in_ready;
    assign out_fire = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            waiting <= '0;
        end else if (in_fire && !out_fire) begin
            waiting <= waiting + 1'b1;
        end else if (!in_fire && out_fire) begin
            waiting <= waiting - 1'b1;
        end
    end

    a_empty_after_reset: assert property (@(posedge clk) rst |=> !out_valid)
        else $error("out_valid high in the cycle after reset");

    a_out_stable: assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
        else $error("output record changed while stalled");

    a_full_not_ready: assert property (@(posedge clk) disable iff (rst)
        (waiting == cnt_w'(`RV_QUEUE_DEPTH)) |-> !in_ready)
        else $error("in_ready high with the queue full");

endmodule

bind rv_decode_top rv_decode_properties i_properties (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
);

// File: test/rv_decode_tb.sv
`include "rv_decode_cfg.svh"

module rv_decode_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import rv_decode_pkg::*;

    localparam int cycle_ns  = 40;
    localparam int num_instr = 2000;

    // operation tables indexed by funct3 with op_none in reserved slots
    localparam op_e alu_ops [8] = '{op_add, op_sll, op_slt, op_sltu,
                                    op_xor, op_srl, op_or, op_and};
    localparam op_e imm_ops [8] = '{op_addi, op_slli, op_slti, op_sltiu,
                                    op_xori, op_srli, op_ori, op_andi};
    localparam op_e br_ops [8]  = '{op_beq, op_bne, op_none, op_none,
                                    op_blt, op_bge, op_bltu, op_bgeu};
    localparam op_e ld_ops [8]  = '{op_lb, op_lh, op_lw, op_none,
                                    op_lbu, op_lhu, op_none, op_none};
    localparam op_e st_ops [8]  = '{op_sb, op_sh, op_sw, op_none,
                                    op_none, op_none, op_none, op_none};
    localparam op_e csr_ops [8] = '{op_none, op_csrrw, op_csrrs, op_csrrc,
                                    op_none, op_csrrwi, op_csrrsi, op_csrrci};
    localparam logic [4:0] opcodes [11] = '{5'b00000, 5'b00100, 5'b00101, 5'b01000,
                                            5'b01100, 5'b01101, 5'b11000, 5'b11001,
                                            5'b11011, 5'b11100, 5'b11111};
    localparam logic [31:0] sys_words [5] = '{32'h00000073, 32'h00100073, 32'h30200073,
                                              32'h10200073, 32'h10500073};

    logic     clk = 1'b0;
    logic     rst;
    logic     in_valid;
    logic     in_ready;
    fetch_t   in_data;
    logic     out_valid;
    logic     out_ready;
    decoded_t out_data;

    integer   seed;
    int       sent;
    int       checked;
    decoded_t expect_q [$];

    rv_decode_top i_dut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    always #(cycle_ns / 2) clk = ~clk;

    function automatic logic [31:0] rand_u32();
        rand_u32 = $random(seed);
    endfunction

    function automatic logic [31:0] sign_shift(input logic [31:0] v, input int n);
        sign_shift = $signed(v) >>> n; // top bit is the immediate sign
    endfunction

    function automatic logic [31:0] make_word();
        logic [31:0] w;
        logic [31:0] pick;
        logic [31:0] r;
        pick = rand_u32() % 100;
        w    = rand_u32();
        r    = rand_u32();
        if (pick < 70) begin
            w[6:0] = {opcodes[4'(r % 11)], 2'b11};
            if (r[8]) begin
                w[31:25] = r[9] ? 7'h20 : 7'h00; // hit sub, sra and legal shifts
            end
        end else if (pick < 80) begin
            w = sys_words[3'(r % 5)];
        end
        return w;
    endfunction

    function automatic decoded_t model_decode(input logic [31:0] pc, input logic [31:0] w);
        decoded_t   d;
        logic [2:0] f3;
        logic [6:0] f7;
        op_class_e  cls;
        op_e        op;
        logic [31:0] imm;
        f3  = w[14:12];
        f7  = w[31:25];
        cls = cls_illegal;
        op  = op_none;
        imm = '0;
        case (w[6:2])
            5'b01100: begin
                cls = cls_alu_reg;
                op  = alu_ops[f3];
                if (w[30] && f3 == 3'd0) op = op_sub;
                if (w[30] && f3 == 3'd5) op = op_sra;
            end
            5'b00100: begin
                cls = cls_alu_imm;
                imm = sign_shift(w, 20);
                op  = imm_ops[f3];
                if (f3 == 3'd1 && f7 != 7'h00) op = op_none;
                if (f3 == 3'd5) begin
                    op = (f7 == 7'h00) ? op_srli : (f7 == 7'h20) ? op_srai : op_none;
                end
            end
            5'b11000: begin
                cls = cls_branch;
                op  = br_ops[f3];
                imm = sign_shift({w[31], w[7], w[30:25], w[11:8], 1'b0, 19'b0}, 19);
            end
            5'b11011: begin
                cls = cls_jal;
                op  = op_jal;
                imm = sign_shift({w[31], w[19:12], w[20], w[30:21], 1'b0, 11'b0}, 11);
            end
            5'b11001: begin
                cls = cls_jalr;
                op  = (f3 == 3'd0) ? op_jalr : op_none;
                imm = sign_shift(w, 20);
            end
            5'b01101: begin
                cls = cls_lui;
                op  = op_lui;
                imm = {w[31:12], 12'b0};
            end
            5'b00101: begin
                cls = cls_auipc;
                op  = op_auipc;
                imm = {w[31:12], 12'b0};
            end
            5'b00000: begin
                cls = cls_load;
                op  = ld_ops[f3];
                imm = sign_shift(w, 20);
            end
            5'b01000: begin
                cls = cls_store;
                op  = st_ops[f3];
                imm = sign_shift({w[31:25], w[11:7], 20'b0}, 20);
            end
            5'b11100: begin
                imm = sign_shift(w, 20);
                cls = (f3 == 3'd0) ? cls_system : cls_csr;
                op  = csr_ops[f3];
                if (f3 == 3'd0) begin
                    case (w)
                        32'h00000073: op = op_ecall;
                        32'h00100073: op = op_ebreak;
                        32'h30200073: op = op_mret;
                        32'h10200073: op = op_sret;
                        32'h10500073: op = op_wfi;
                        default:      op = op_none;
                    endcase
                end
            end
            5'b11111: begin
                cls = cls_custom;
                op  = op_custom;
            end
            default: cls = cls_illegal;
        endcase
        if (w[1:0] != 2'b11) op = op_none;
        d.pc = pc; // kept even when illegal
        if (op == op_none) begin
            d.op_class = cls_illegal;
            d.op       = op_none;
            d.rd       = '0;
            d.rs1      = '0;
            d.rs2      = '0;
            d.imm      = '0;
            d.target   = '0;
            d.cause    = `RV_CAUSE_ILLEGAL;
        end else begin
            d.op_class = cls;
            d.op       = op;
            d.rd       = w[11:7];
            d.rs1      = w[19:15];
            d.rs2      = w[24:20];
            d.imm      = imm;
            d.target   = pc + imm;
            d.cause    = 4'd0;
        end
        return d;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_field(input string name, input logic [31:0] want,
                               input logic [31:0] got);
        if (want !== got) begin
            abort_run($sformatf("ERROR: %s expected 0x%h actual 0x%h", name, want, got));
        end
    endtask

    // records pending in the model match the DUT queue at the falling edge
    task automatic check_flags();
        check_field("random_decode in_ready",
                    32'(expect_q.size() < `RV_QUEUE_DEPTH), 32'(in_ready));
        check_field("random_decode out_valid",
                    32'(expect_q.size() != 0), 32'(out_valid));
    endtask

    task automatic compare_record();
        decoded_t want;
        string    tag;
        want = expect_q.pop_front();
        tag  = $sformatf("random_decode #%0d", checked);
        check_field({tag, " pc"}, want.pc, out_data.pc);
        check_field({tag, " op_class"}, 32'(want.op_class), 32'(out_data.op_class));
        check_field({tag, " op"}, 32'(want.op), 32'(out_data.op));
        check_field({tag, " rd"}, 32'(want.rd), 32'(out_data.rd));
        check_field({tag, " rs1"}, 32'(want.rs1), 32'(out_data.rs1));
        check_field({tag, " rs2"}, 32'(want.rs2), 32'(out_data.rs2));
        check_field({tag, " imm"}, want.imm, out_data.imm);
        check_field({tag, " target"}, want.target, out_data.target);
        check_field({tag, " cause"}, 32'(want.cause), 32'(out_data.cause));
        checked++;
    endtask

    initial begin
        #(num_instr * 20 * cycle_ns); // 20 cycles per instruction
        abort_run("decode stage stopped delivering instructions");
    end

    initial begin
        logic        in_fire;
        logic [31:0] pc_r;
        logic [31:0] word_r;
        seed      = 32'h9b3bb3d0;
        sent      = 0;
        checked   = 0;
        rst       <= 1'b1;
        in_valid  <= 1'b0;
        in_data   <= '0;
        out_ready <= 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        while (checked < num_instr) begin
            @(negedge clk); // handshake signals settled here
            check_flags();
            if (out_valid && out_ready) begin
                compare_record();
            end
            in_fire = in_valid && in_ready;
            if (in_fire) begin
                expect_q.push_back(model_decode(in_data.pc, in_data.word));
            end
            @(posedge clk);
            if (in_fire) sent++;
            if (!in_valid || in_fire) begin // hold until accepted
                if (sent < num_instr && (rand_u32() % 4) != 0) begin
                    pc_r         = rand_u32();
                    word_r       = make_word();
                    in_valid     <= 1'b1;
                    in_data.pc   <= pc_r;
                    in_data.word <= word_r;
                end else begin
                    in_valid <= 1'b0;
                end
            end
            out_ready <= (rand_u32() % 3) != 0;
        end
        @(negedge clk); // drained queue stays empty
        check_flags();
        $display("STATUS: PASS");
        $finish;
    end

endmodule
